//--- mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [2:0]  cca_t;
    typedef logic [3:0]  wstrb_t;

    typedef enum logic [1:0] {
        NONE  = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // LEFT covers lwl/swl, RIGHT covers lwr/swr
    typedef enum logic [1:0] {
        NORMAL = 2'd0,
        LEFT   = 2'd1,
        RIGHT  = 2'd2
    } mem_align_e;

    typedef struct packed {
        mem_op_e    op;
        mem_size_e  size;
        mem_align_e align;
        logic       ll;
        logic       sc;
        word_t      vaddr;
        word_t      rt;     // store data from gpr rt
    } mem_req_t;

    typedef struct packed {
        logic found;
        logic v;
        logic d;
        pfn_t pfn;
        cca_t c;
    } tlb_result_t;

    typedef struct packed {
        logic bev;
        logic exl;
        logic iv;
        cca_t k0;   // config.k0, kseg0 attribute
    } cp0_ctrl_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
    } prev_exc_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     badvaddr;
        logic      tlb_refill;
    } exc_out_t;

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;
    localparam exc_code_t EXC_TRAP = 5'd13;

    localparam cca_t CCA_CACHED = 3'd3;

    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    localparam word_t VEC_REFILL_RAM  = 32'h8000_0000;
    localparam word_t VEC_GENERAL_RAM = 32'h8000_0180;
    localparam word_t VEC_INT_RAM     = 32'h8000_0200;
    localparam word_t VEC_REFILL_ROM  = 32'hBFC0_0200;
    localparam word_t VEC_GENERAL_ROM = 32'hBFC0_0380;
    localparam word_t VEC_INT_ROM     = 32'hBFC0_0400;

endpackage

`default_nettype wire

//--- addr_translate.sv
`default_nettype none

module addr_translate
    import mem_access_pkg::*;
(
    input  mem_req_t    req,
    input  tlb_result_t tlb,
    input  cca_t        k0,
    output word_t       paddr,
    output logic        mapped,
    output logic        uncached
);

    logic active;
    logic kseg0;
    logic kseg1;
    logic k0_uncached;
    logic tlb_uncached;

    assign active = (req.op != NONE);

    // kuseg and kseg2/kseg3 go through the tlb
    assign mapped = active && (!req.vaddr[31] || (req.vaddr[31] && req.vaddr[30]));

    assign paddr = mapped ? {tlb.pfn, req.vaddr[11:0]}
                          : {3'b000, req.vaddr[28:0]};

    assign kseg0 = (req.vaddr[31:29] == SEG_KSEG0);
    assign kseg1 = (req.vaddr[31:29] == SEG_KSEG1);

    assign k0_uncached  = kseg0 && (k0 != CCA_CACHED);
    assign tlb_uncached = mapped && (tlb.c != CCA_CACHED);

    // idle slot also reports uncached
    assign uncached = kseg1 || k0_uncached || tlb_uncached || !active;

endmodule

`default_nettype wire

//--- mem_exc_detect.sv
`default_nettype none

module mem_exc_detect
    import mem_access_pkg::*;
(
    input  mem_req_t    req,
    input  tlb_result_t tlb,
    input  logic        mapped,
    input  word_t       pc,
    input  prev_exc_t   prev_exc,
    input  logic        interrupt,
    input  logic        overflow,
    input  logic        trap,
    output exc_out_t    exc
);

    logic is_load;
    logic is_store;
    logic misalign;
    logic ades;
    logic adel;
    logic tlb_miss;     // refill or invalid entry
    logic tlbl;
    logic tlbs;
    logic tlbmod;

    assign is_load  = (req.op == LOAD);
    assign is_store = (req.op == STORE);

    // lwl/lwr/swl/swr never fault on alignment
    always_comb begin
        misalign = 1'b0;
        if (req.align == NORMAL) begin
            case (req.size)
                HALF:    misalign = req.vaddr[0];
                WORD:    misalign = |req.vaddr[1:0];
                default: misalign = 1'b0;
            endcase
        end
    end

    assign ades = is_store && misalign;
    assign adel = is_load && misalign;

    assign tlb_miss = mapped && (!tlb.found || !tlb.v);
    assign tlbl     = tlb_miss && is_load;
    assign tlbs     = tlb_miss && is_store;
    assign tlbmod   = mapped && is_store && tlb.found && tlb.v && !tlb.d;

    always_comb begin
        exc = '0;
        if (interrupt) begin
            exc.valid = 1'b1;
            exc.code  = EXC_INT;
        end else if (prev_exc.valid) begin
            exc.valid    = 1'b1;
            exc.code     = prev_exc.code;
            exc.badvaddr = pc;  // earlier faults report their own pc
        end else if (overflow) begin
            exc.valid = 1'b1;
            exc.code  = EXC_OV;
        end else if (trap) begin
            exc.valid = 1'b1;
            exc.code  = EXC_TRAP;
        end else if (ades) begin
            exc.valid    = 1'b1;
            exc.code     = EXC_ADES;
            exc.badvaddr = req.vaddr;
        end else if (adel) begin
            exc.valid    = 1'b1;
            exc.code     = EXC_ADEL;
            exc.badvaddr = req.vaddr;
        end else if (tlbl || tlbs) begin
            exc.valid      = 1'b1;
            exc.code       = tlbl ? EXC_TLBL : EXC_TLBS;
            exc.badvaddr   = req.vaddr;
            exc.tlb_refill = !tlb.found;
        end else if (tlbmod) begin
            exc.valid    = 1'b1;
            exc.code     = EXC_MOD;
            exc.badvaddr = req.vaddr;
        end
    end

endmodule

`default_nettype wire

//--- ll_sc_link.sv
`default_nettype none

module ll_sc_link
    import mem_access_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t req,
    input  logic     exc_valid,
    input  logic     redirect_valid,
    output logic     sc_ok
);

    logic  link;
    word_t link_addr;
    logic  ll_done;

    assign ll_done = req.ll && (req.op == LOAD) && !exc_valid;

    // any exception or eret breaks the link
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            link <= 1'b0;
        end else if (redirect_valid) begin
            link <= 1'b0;
        end else if (ll_done) begin
            link <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ll_done) begin
            link_addr <= req.vaddr;
        end
    end

    assign sc_ok = req.sc && (req.op == STORE) && link && (link_addr == req.vaddr);

endmodule

`default_nettype wire

//--- store_align.sv
`default_nettype none

module store_align
    import mem_access_pkg::*;
(
    input  mem_req_t   req,
    input  logic [1:0] addr_lo,     // paddr[1:0]
    input  logic       store_en,
    output wstrb_t     wstrb,
    output word_t      wdata
);

    always_comb begin
        wstrb = '0;
        if (store_en) begin
            case (req.align)
                LEFT: begin     // swl
                    case (addr_lo)
                        2'd0:    wstrb = 4'b0001;
                        2'd1:    wstrb = 4'b0011;
                        2'd2:    wstrb = 4'b0111;
                        default: wstrb = 4'b1111;
                    endcase
                end
                RIGHT: begin    // swr
                    case (addr_lo)
                        2'd0:    wstrb = 4'b1111;
                        2'd1:    wstrb = 4'b1110;
                        2'd2:    wstrb = 4'b1100;
                        default: wstrb = 4'b1000;
                    endcase
                end
                default: begin
                    case (req.size)
                        BYTE:    wstrb = 4'b0001 << addr_lo;
                        HALF:    wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
                        default: wstrb = 4'b1111;
                    endcase
                end
            endcase
        end
    end

    // partial word stores move rt into the lanes picked by the strobes
    always_comb begin
        wdata = req.rt;
        if (req.align == LEFT) begin
            case (wstrb)
                4'b0001: wdata = {4{req.rt[31:24]}};
                4'b0011: wdata = {2{req.rt[31:16]}};
                4'b0111: wdata = {8'h00, req.rt[31:8]};
                default: wdata = req.rt;
            endcase
        end else if (req.align == RIGHT) begin
            case (wstrb)
                4'b1000: wdata = {4{req.rt[7:0]}};
                4'b1100: wdata = {2{req.rt[15:0]}};
                4'b1110: wdata = {req.rt[23:0], 8'h00};
                default: wdata = req.rt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- exc_vector_sel.sv
`default_nettype none

module exc_vector_sel
    import mem_access_pkg::*;
(
    input  exc_out_t  exc,
    input  logic      interrupt,
    input  logic      eret,
    input  word_t     epc,
    input  cp0_ctrl_t cp0,
    output logic      redirect_valid,
    output word_t     redirect_pc
);

    word_t vec_general;
    word_t vec_int;
    word_t vec_refill;

    // bev selects the boot rom region
    assign vec_general = cp0.bev ? VEC_GENERAL_ROM : VEC_GENERAL_RAM;
    assign vec_int     = cp0.bev ? VEC_INT_ROM     : VEC_INT_RAM;
    assign vec_refill  = cp0.bev ? VEC_REFILL_ROM  : VEC_REFILL_RAM;

    assign redirect_valid = exc.valid || eret;

    always_comb begin
        redirect_pc = '0;
        if (exc.valid) begin
            if (interrupt) begin
                if (cp0.exl)
                    redirect_pc = vec_general;
                else
                    redirect_pc = cp0.iv ? vec_int : vec_general;
            end else if (exc.tlb_refill && !cp0.exl) begin
                redirect_pc = vec_refill;
            end else begin
                redirect_pc = vec_general;  // nested refill lands here too
            end
        end else if (eret) begin
            redirect_pc = epc;
        end
    end

endmodule

`default_nettype wire

//--- mem1_stage.sv
`default_nettype none

module mem1_stage
    import mem_access_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  mem_req_t    req,
    input  tlb_result_t tlb,
    input  cp0_ctrl_t   cp0,
    input  prev_exc_t   prev_exc,
    input  word_t       pc,
    input  word_t       epc,
    input  logic        interrupt,
    input  logic        overflow,
    input  logic        trap,
    input  logic        eret,
    output word_t       paddr,
    output logic        uncached,
    output logic        cache_valid,
    output logic        uncache_valid,
    output logic        sc_result,
    output wstrb_t      wstrb,
    output word_t       wdata,
    output exc_out_t    exc,
    output logic        redirect_valid,
    output word_t       redirect_pc
);

    logic mapped;
    logic sc_ok;
    logic sc_req;
    logic access_en;    // access actually goes to memory
    logic store_en;

    addr_translate u_addr_translate (
        .req      (req),
        .tlb      (tlb),
        .k0       (cp0.k0),
        .paddr    (paddr),
        .mapped   (mapped),
        .uncached (uncached)
    );

    mem_exc_detect u_mem_exc_detect (
        .req       (req),
        .tlb       (tlb),
        .mapped    (mapped),
        .pc        (pc),
        .prev_exc  (prev_exc),
        .interrupt (interrupt),
        .overflow  (overflow),
        .trap      (trap),
        .exc       (exc)
    );

    ll_sc_link u_ll_sc_link (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .exc_valid      (exc.valid),
        .redirect_valid (redirect_valid),
        .sc_ok          (sc_ok)
    );

    assign sc_req = req.sc && (req.op == STORE);

    // a failed sc is dropped silently
    assign access_en = (req.op != NONE) && !exc.valid && !(sc_req && !sc_ok);
    assign store_en  = access_en && (req.op == STORE);

    assign cache_valid   = access_en && !uncached;
    assign uncache_valid = access_en && uncached;
    assign sc_result     = access_en && sc_req;

    store_align u_store_align (
        .req      (req),
        .addr_lo  (paddr[1:0]),
        .store_en (store_en),
        .wstrb    (wstrb),
        .wdata    (wdata)
    );

    exc_vector_sel u_exc_vector_sel (
        .exc            (exc),
        .interrupt      (interrupt),
        .eret           (eret),
        .epc            (epc),
        .cp0            (cp0),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- mem1_stage_properties.sv
`default_nettype none

module mem1_stage_properties
    import mem_access_pkg::*;
(
    input wire logic     clk,
    input wire logic     arst_n,
    input wire logic     cache_valid,
    input wire logic     uncache_valid,
    input wire wstrb_t   wstrb,
    input wire exc_out_t exc,
    input wire logic     eret,
    input wire logic     redirect_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // one path per access
    valid_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(cache_valid && uncache_valid))
        else $error("cache_valid and uncache_valid high together");

    no_strobe_on_exc: assert property (@(posedge clk) disable iff (!arst_n)
        exc.valid |-> (wstrb == 4'b0000))
        else $error("store strobes active during an exception");

    redirect_follows: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid == (exc.valid || eret))
        else $error("redirect_valid does not follow exception or eret");

endmodule

bind mem1_stage mem1_stage_properties u_properties (
    .clk            (clk),
    .arst_n         (arst_n),
    .cache_valid    (cache_valid),
    .uncache_valid  (uncache_valid),
    .wstrb          (wstrb),
    .exc            (exc),
    .eret           (eret),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

//--- tb_mem1_stage.sv
`default_nettype none

module tb_mem1_stage
    import mem_access_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CYCLES     = 2000;
    localparam int RESET_CYCLES   = 2;
    localparam int MID_RESET      = 1000;   // one reset pulse in the middle of the run
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 98;

    logic        clk;
    logic        arst_n;
    mem_req_t    req;
    tlb_result_t tlb;
    cp0_ctrl_t   cp0;
    prev_exc_t   prev_exc;
    word_t       pc;
    word_t       epc;
    logic        interrupt;
    logic        overflow;
    logic        trap;
    logic        eret;
    word_t       paddr;
    logic        uncached;
    logic        cache_valid;
    logic        uncache_valid;
    logic        sc_result;
    wstrb_t      wstrb;
    word_t       wdata;
    exc_out_t    exc;
    logic        redirect_valid;
    word_t       redirect_pc;

    word_t rng;
    int    errors;
    int    checks;
    int    cycle_count;
    logic  link_m;          // reference copy of the ll/sc link
    word_t link_addr_m;

    mem1_stage dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .tlb            (tlb),
        .cp0            (cp0),
        .prev_exc       (prev_exc),
        .pc             (pc),
        .epc            (epc),
        .interrupt      (interrupt),
        .overflow       (overflow),
        .trap           (trap),
        .eret           (eret),
        .paddr          (paddr),
        .uncached       (uncached),
        .cache_valid    (cache_valid),
        .uncache_valid  (uncache_valid),
        .sc_result      (sc_result),
        .wstrb          (wstrb),
        .wdata          (wdata),
        .exc            (exc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // a few lines, one per segment, so ll/sc pairs hit the same address
    function automatic word_t line_addr(input logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h0000_1040;  // kuseg
            2'd1:    return 32'h8000_2200;  // kseg0
            2'd2:    return 32'ha000_3300;  // kseg1
            default: return 32'hc004_0080;  // kseg2
        endcase
    endfunction

    function automatic mem_size_e size_pick(input logic [1:0] s);
        case (s)
            2'd0:    return BYTE;
            2'd1:    return HALF;
            default: return WORD;
        endcase
    endfunction

    function automatic logic in_mapped_seg(input mem_req_t r);
        return (r.op != NONE) && (r.vaddr[31] == 1'b0 || r.vaddr[31:30] == 2'b11);
    endfunction

    function automatic word_t translate_addr(input mem_req_t r, input tlb_result_t t);
        if (in_mapped_seg(r))
            return {t.pfn, r.vaddr[11:0]};
        return {3'b000, r.vaddr[28:0]};
    endfunction

    function automatic logic is_uncached(input mem_req_t r, input tlb_result_t t,
                                         input cca_t k0);
        if (r.op == NONE)
            return 1'b1;
        if (r.vaddr[31:29] == SEG_KSEG1)
            return 1'b1;
        if (r.vaddr[31:29] == SEG_KSEG0)
            return k0 != CCA_CACHED;
        if (in_mapped_seg(r))
            return t.c != CCA_CACHED;
        return 1'b0;
    endfunction

    function automatic exc_out_t make_exc(input exc_code_t code, input word_t bad,
                                          input logic refill);
        exc_out_t e;
        e.valid      = 1'b1;
        e.code       = code;
        e.badvaddr   = bad;
        e.tlb_refill = refill;
        return e;
    endfunction

    function automatic exc_out_t prioritise_exc(input mem_req_t r, input tlb_result_t t,
                                                input word_t pc_i, input prev_exc_t pe,
                                                input logic intr, input logic ov,
                                                input logic tr);
        logic ld;
        logic st;
        logic mis;
        logic map;
        ld  = (r.op == LOAD);
        st  = (r.op == STORE);
        mis = (r.align == NORMAL) &&
              ((r.size == HALF && r.vaddr[0]) || (r.size == WORD && r.vaddr[1:0] != 2'b00));
        map = in_mapped_seg(r);
        if (intr)
            return make_exc(EXC_INT, '0, 1'b0);
        if (pe.valid)
            return make_exc(pe.code, pc_i, 1'b0);
        if (ov)
            return make_exc(EXC_OV, '0, 1'b0);
        if (tr)
            return make_exc(EXC_TRAP, '0, 1'b0);
        if (st && mis)
            return make_exc(EXC_ADES, r.vaddr, 1'b0);
        if (ld && mis)
            return make_exc(EXC_ADEL, r.vaddr, 1'b0);
        if (map && !(t.found && t.v))
            return make_exc(ld ? EXC_TLBL : EXC_TLBS, r.vaddr, !t.found);
        if (map && st && !t.d)
            return make_exc(EXC_MOD, r.vaddr, 1'b0);
        return '0;
    endfunction

    // lanes written, lane 0 being the lowest byte address
    function automatic wstrb_t strobe_for(input mem_req_t r, input logic [1:0] lo,
                                          input logic en);
        wstrb_t s;
        int     k;
        s = '0;
        k = int'(lo);
        for (int i = 0; i < 4; i++) begin
            case (r.align)
                LEFT:    s[i] = (i <= k);
                RIGHT:   s[i] = (i >= k);
                default: begin
                    case (r.size)
                        BYTE:    s[i] = (i == k);
                        HALF:    s[i] = (i / 2 == k / 2);
                        default: s[i] = 1'b1;
                    endcase
                end
            endcase
        end
        return en ? s : 4'b0000;
    endfunction

    function automatic word_t shift_data(input mem_req_t r, input wstrb_t s);
        if (r.align == LEFT) begin
            case (s)
                4'b0001: return {4{r.rt[31:24]}};
                4'b0011: return {2{r.rt[31:16]}};
                4'b0111: return {8'h00, r.rt[31:8]};
                default: return r.rt;
            endcase
        end
        if (r.align == RIGHT) begin
            case (s)
                4'b1000: return {4{r.rt[7:0]}};
                4'b1100: return {2{r.rt[15:0]}};
                4'b1110: return {r.rt[23:0], 8'h00};
                default: return r.rt;
            endcase
        end
        return r.rt;
    endfunction

    function automatic word_t redirect_for(input exc_out_t e, input logic intr,
                                           input logic er, input word_t epc_i,
                                           input cp0_ctrl_t c);
        if (e.valid) begin
            if (intr && !c.exl && c.iv)
                return c.bev ? VEC_INT_ROM : VEC_INT_RAM;
            if (!intr && e.tlb_refill && !c.exl)
                return c.bev ? VEC_REFILL_ROM : VEC_REFILL_RAM;
            return c.bev ? VEC_GENERAL_ROM : VEC_GENERAL_RAM;
        end
        return er ? epc_i : 32'h0000_0000;
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic drive_random();
        word_t r0;
        word_t r1;
        word_t r3;
        word_t r4;
        r0 = rand_word();
        r1 = rand_word();
        r3 = rand_word();
        r4 = rand_word();
        req       = '0;
        req.rt    = rand_word();
        req.vaddr = r1;
        if (r0[5:3] < 3'd5)
            req.vaddr = line_addr(r0[7:6]) | {30'd0, r1[1:0]};
        case (r0[2:0])
            3'd0: req.op = NONE;
            3'd1: begin
                req.op   = LOAD;
                req.size = size_pick(r0[9:8]);
            end
            3'd2: begin
                req.op   = STORE;
                req.size = size_pick(r0[9:8]);
            end
            3'd3, 3'd4: begin   // swl, swr
                req.op    = STORE;
                req.size  = WORD;
                req.align = (r0[2:0] == 3'd3) ? LEFT : RIGHT;
            end
            3'd5: begin
                req.op    = LOAD;
                req.size  = WORD;
                req.align = r0[10] ? LEFT : RIGHT;
            end
            3'd6: begin
                req.op    = LOAD;
                req.size  = WORD;
                req.ll    = 1'b1;
                req.vaddr = line_addr(r0[7:6]);
            end
            default: begin
                req.op    = STORE;
                req.size  = WORD;
                req.sc    = 1'b1;
                req.vaddr = line_addr(r0[7:6]);
            end
        endcase
        tlb.found     = r3[2:0] != 3'd0;
        tlb.v         = r3[5:3] != 3'd0;
        tlb.d         = r3[7:6] != 2'd0;
        tlb.c         = r3[11] ? CCA_CACHED : r3[10:8];
        tlb.pfn       = r3[31:12];
        interrupt     = r4[3:0] == 4'd0;
        overflow      = r4[7:4] == 4'd0;
        trap          = r4[11:8] == 4'd0;
        prev_exc.valid = r4[15:12] == 4'd0;
        prev_exc.code = r4[20:16];
        eret          = r4[24:21] == 4'd0;
        cp0.bev       = r4[25];
        cp0.exl       = r4[26];
        cp0.iv        = r4[27];
        cp0.k0        = r4[31] ? CCA_CACHED : r4[30:28];
        pc            = rand_word();
        epc           = rand_word();
    endtask

    // fault free ll or sc to the kseg1 line
    task automatic pin_link_access(input logic sc);
        req.op         = sc ? STORE : LOAD;
        req.size       = WORD;
        req.align      = NORMAL;
        req.ll         = !sc;
        req.sc         = sc;
        req.vaddr      = line_addr(2'd2);
        interrupt      = 1'b0;
        overflow       = 1'b0;
        trap           = 1'b0;
        prev_exc.valid = 1'b0;
        eret           = 1'b0;
    endtask

    task automatic check_cycle();
        exc_out_t e_exc;
        word_t    e_paddr;
        logic     e_unc;
        logic     sc_req;
        logic     sc_ok_m;
        logic     perf;
        wstrb_t   e_strb;
        e_paddr = translate_addr(req, tlb);
        e_unc   = is_uncached(req, tlb, cp0.k0);
        e_exc   = prioritise_exc(req, tlb, pc, prev_exc, interrupt, overflow, trap);
        sc_req  = req.sc && (req.op == STORE);
        sc_ok_m = sc_req && link_m && (link_addr_m == req.vaddr);
        perf    = (req.op != NONE) && !e_exc.valid && !(sc_req && !sc_ok_m);
        e_strb  = strobe_for(req, e_paddr[1:0], perf && (req.op == STORE));
        check_val("paddr", paddr, e_paddr);
        check_val("uncached", 32'(uncached), 32'(e_unc));
        check_val("cache_valid", 32'(cache_valid), 32'(perf && !e_unc));
        check_val("uncache_valid", 32'(uncache_valid), 32'(perf && e_unc));
        check_val("sc_result", 32'(sc_result), 32'(perf && sc_req));
        check_val("wstrb", 32'(wstrb), 32'(e_strb));
        check_val("wdata", wdata, shift_data(req, e_strb));
        check_val("exc.valid", 32'(exc.valid), 32'(e_exc.valid));
        check_val("exc.code", 32'(exc.code), 32'(e_exc.code));
        check_val("exc.badvaddr", exc.badvaddr, e_exc.badvaddr);
        check_val("exc.tlb_refill", 32'(exc.tlb_refill), 32'(e_exc.tlb_refill));
        check_val("redirect_valid", 32'(redirect_valid), 32'(e_exc.valid || eret));
        check_val("redirect_pc", redirect_pc, redirect_for(e_exc, interrupt, eret, epc, cp0));
        // link state as it will be after the coming edge
        if (!arst_n) begin
            link_m = 1'b0;
        end else begin
            if (req.ll && req.op == LOAD && !e_exc.valid)
                link_addr_m = req.vaddr;
            if (e_exc.valid || eret)
                link_m = 1'b0;
            else if (req.ll && req.op == LOAD)
                link_m = 1'b1;
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        rng         = 32'hfaf3_3d10;
        link_m      = 1'b0;
        link_addr_m = '0;
        arst_n      = 1'b0;
        req         = '0;
        tlb         = '0;
        cp0         = '0;
        prev_exc    = '0;
        pc          = '0;
        epc         = '0;
        interrupt   = 1'b0;
        overflow    = 1'b0;
        trap        = 1'b0;
        eret        = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            #1;
            arst_n = (n != MID_RESET);
            if (!arst_n)
                link_m = 1'b0;
            drive_random();
            // ll just before the reset pulse, sc to the same line right after it
            if (n == MID_RESET - 1)
                pin_link_access(1'b0);
            else if (n == MID_RESET + 1)
                pin_link_access(1'b1);
            #6;
            check_cycle();
        end
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d errors", cycle_count, errors);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
mem_access_pkg.sv
addr_translate.sv
mem_exc_detect.sv
ll_sc_link.sv
store_align.sv
exc_vector_sel.sv
mem1_stage.sv
mem1_stage_properties.sv
tb_mem1_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_mem1_stage -o tb_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "sim passed" && exit 0 || exit 1
